// ==== verilog.f ====
+incdir+.
paddle_pkg.sv
slot_if.sv
motion_detect.sv
source_scanner.sv
mouse_tracker.sv
paddle_allocator.sv
paddle_output_mux.sv
paddle_chooser.sv
tb_paddle_chooser.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the paddle chooser testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_paddle_chooser -f verilog.f -o sim_paddle_chooser
out=$(./obj_dir/sim_paddle_chooser)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1

// ==== tb_paddle_chooser.sv ====
// paddle chooser testbench
// directed tests for reset state, spinner, stick and mouse claims,
// mouse tracking and the slot enable mask

`timescale 1ns/1ps
`default_nettype none

`include "paddle_config.svh"

module tb_paddle_chooser
	import paddle_pkg::*;
();
	localparam int NUM_TESTS = 5;
	// longest wait for an assignment strobe
	localparam int WAIT_LIMIT = 20;

	logic                              clk;
	logic                              reset;
	port_mask_t                        mask;
	mouse_pkt_t                        mouse;
	stick_t       [`PADDLE_PORTS-1:0]  analog;
	paddle_val_t  [`PADDLE_PORTS-1:0]  paddle;
	port_mask_t                        buttons_in;
	port_mask_t                        assigned;
	paddle_val_t  [`PADDLE_PORTS-1:0]  pd_out;
	source_kind_e [`PADDLE_PORTS-1:0]  paddle_type;
	port_mask_t                        paddle_but;

	int          error_count;
	int          check_count;
	int          tests_run;
	int          tests_failed;
	// expected mouse position after the packets sent so far
	int          mouse_pos;

	paddle_chooser paddle_chooser_i (
		.clk         (clk),
		.reset       (reset),
		.mask        (mask),
		.mouse       (mouse),
		.analog      (analog),
		.paddle      (paddle),
		.buttons_in  (buttons_in),
		.assigned    (assigned),
		.pd_out      (pd_out),
		.paddle_type (paddle_type),
		.paddle_but  (paddle_but)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ends a stuck run after 200 cycles per test
	initial begin
		repeat (NUM_TESTS * 200) @(posedge clk);
		$display("watchdog expired after %0d cycles, run did not finish", NUM_TESTS * 200);
		$display("Testbench failed");
		$finish;
	end

	task automatic check_val(input string name, input paddle_val_t got, input paddle_val_t exp);
		check_count++;
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_kind(input string name, input source_kind_e got, input source_kind_e exp);
		check_count++;
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_mask(input string name, input port_mask_t got, input port_mask_t exp);
		check_count++;
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	// random rest position with the top two bits 01 or 10
	function automatic paddle_val_t rand_mid();
		return 8'h40 + paddle_val_t'($urandom % 128);
	endfunction

	// PS/2 step model that clamps the step and then saturates the sum
	function automatic int next_mouse_pos(input int pos, input logic sign,
		input logic [7:0] mag, input logic ovf);
		int step;
		int sum;
		if (ovf) begin
			step = sign ? -`MOUSE_STEP_LIMIT : `MOUSE_STEP_LIMIT;
		end else begin
			// sign and byte form a 9-bit two's complement delta
			step = sign ? int'(mag) - 256 : int'(mag);
			if (step > `MOUSE_STEP_LIMIT)
				step = `MOUSE_STEP_LIMIT;
			else if (step < -`MOUSE_STEP_LIMIT)
				step = -`MOUSE_STEP_LIMIT;
		end
		sum = pos + step;
		if (sum < `MOUSE_POS_MIN)
			sum = `MOUSE_POS_MIN;
		else if (sum > `MOUSE_POS_MAX)
			sum = `MOUSE_POS_MAX;
		return sum;
	endfunction

	// inverted offset binary of the position
	function automatic paddle_val_t expected_mouse_out(input int pos);
		return ~paddle_val_t'(pos + 128);
	endfunction

	// returns the inputs to rest and holds reset for 5 cycles
	task automatic apply_reset(input port_mask_t new_mask);
		@(posedge clk);
		reset <= 1'b1;
		mask <= new_mask;
		mouse.button <= 1'b0;
		mouse.x_ovf <= 1'b0;
		mouse.x_sign <= 1'b0;
		mouse.x_delta <= '0;
		buttons_in <= port_mask_t'($urandom);
		for (int i = 0; i < `PADDLE_PORTS; i++) begin
			paddle[i] <= rand_mid();
			// stick raw value is the offset value with its sign bit flipped
			analog[i].x <= rand_mid() ^ 8'h80;
			analog[i].y <= rand_mid() ^ 8'h80;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		mouse_pos = 0;
		@(negedge clk);
	endtask

	task automatic move_spinner(input int idx, input paddle_val_t v);
		@(posedge clk);
		paddle[idx] <= v;
	endtask

	// waits for the one-cycle assignment strobe after a move
	task automatic expect_assign(input port_mask_t exp);
		int edges;
		edges = 0;
		@(negedge clk);
		while ((assigned == '0) && (edges < WAIT_LIMIT)) begin
			@(negedge clk);
			edges++;
		end
		if (assigned == '0) begin
			$display("no slot was assigned within %0d cycles of the move", WAIT_LIMIT);
			error_count++;
		end else begin
			if (edges != 2) begin
				$display("slot was assigned %0d edges after the move instead of 2", edges);
				error_count++;
			end
			check_mask("assigned", assigned, exp);
			@(negedge clk);
			check_mask("assigned", assigned, '0);
		end
	endtask

	task automatic expect_none(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_mask("assigned", assigned, '0);
		end
	endtask

	// sends one packet and checks the position two edges after the strobe toggle
	task automatic send_mouse_step(input logic sign, input logic [7:0] mag, input logic ovf);
		@(posedge clk);
		mouse.x_sign <= sign;
		mouse.x_delta <= mag;
		mouse.x_ovf <= ovf;
		mouse.strobe <= ~mouse.strobe;
		mouse_pos = next_mouse_pos(mouse_pos, sign, mag, ovf);
		repeat (3) @(negedge clk);
		check_val("pd_out[0]", pd_out[0], expected_mouse_out(mouse_pos));
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (error_count == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, error_count - errs_before);
		end
	endtask

	task automatic reset_clears_outputs();
		int errs_before;
		errs_before = error_count;
		apply_reset(4'b1111);
		check_mask("assigned", assigned, '0);
		check_mask("paddle_but", paddle_but, '0);
		for (int i = 0; i < `PADDLE_PORTS; i++) begin
			check_val($sformatf("pd_out[%0d]", i), pd_out[i], '0);
			check_kind($sformatf("paddle_type[%0d]", i), paddle_type[i], SPINNER);
		end
		expect_none(4);
		report_test("reset state", errs_before);
	endtask

	task automatic spinner_takes_slot();
		int         errs_before;
		port_mask_t exp_but;
		errs_before = error_count;
		apply_reset(4'b1111);
		move_spinner(2, 8'hF0);
		expect_assign(4'b0001);
		check_kind("paddle_type[0]", paddle_type[0], SPINNER);
		check_val("pd_out[0]", pd_out[0], ~8'hF0);
		exp_but = '0;
		exp_but[0] = buttons_in[2];
		check_mask("paddle_but", paddle_but, exp_but);
		// button of spinner 2 keeps following
		@(posedge clk);
		buttons_in <= ~buttons_in;
		@(negedge clk);
		exp_but[0] = buttons_in[2];
		check_mask("paddle_but", paddle_but, exp_but);
		// claimed spinner moving again only changes the position
		move_spinner(2, 8'h10);
		expect_none(4);
		check_val("pd_out[0]", pd_out[0], ~8'h10);
		report_test("spinner claim", errs_before);
	endtask

	task automatic stick_takes_slot();
		int         errs_before;
		port_mask_t exp_but;
		errs_before = error_count;
		apply_reset(4'b1111);
		move_spinner(0, 8'h05);
		expect_assign(4'b0001);
		@(posedge clk);
		analog[1].x <= 8'h7A;
		expect_assign(4'b0010);
		check_kind("paddle_type[1]", paddle_type[1], ANALOG);
		check_val("pd_out[1]", pd_out[1], ~(8'h7A ^ 8'h80));
		exp_but = '0;
		exp_but[1:0] = buttons_in[1:0];
		check_mask("paddle_but", paddle_but, exp_but);
		// y of the same stick is already taken along with x
		@(posedge clk);
		analog[1].y <= 8'h85;
		expect_none(8);
		check_val("pd_out[1]", pd_out[1], ~(8'h7A ^ 8'h80));
		report_test("stick claim", errs_before);
	endtask

	task automatic mouse_takes_slot();
		int errs_before;
		errs_before = error_count;
		apply_reset(4'b1111);
		@(posedge clk);
		mouse.button <= 1'b1;
		expect_assign(4'b0001);
		check_kind("paddle_type[0]", paddle_type[0], MOUSE);
		check_val("pd_out[0]", pd_out[0], expected_mouse_out(0));
		check_mask("paddle_but", paddle_but, 4'b0001);
		send_mouse_step(1'b0, 8'd100, 1'b0);
		send_mouse_step(1'b1, 8'hE2, 1'b0);
		send_mouse_step(1'b1, 8'h00, 1'b1);
		send_mouse_step(1'b1, 8'h10, 1'b1);
		// runs into the lower limit
		send_mouse_step(1'b1, 8'h00, 1'b1);
		send_mouse_step(1'b0, 8'h50, 1'b0);
		// fire 0 stands in for the mouse button while stick 0 is free
		@(posedge clk);
		mouse.button <= 1'b0;
		buttons_in <= 4'b0001;
		repeat (2) @(negedge clk);
		check_mask("paddle_but", paddle_but, 4'b0001);
		@(posedge clk);
		buttons_in <= 4'b1110;
		@(negedge clk);
		check_mask("paddle_but", paddle_but, 4'b0000);
		// stick 0 takes slot 1 and with it fire 0
		@(posedge clk);
		analog[0].y <= 8'h80;
		expect_assign(4'b0010);
		check_kind("paddle_type[1]", paddle_type[1], ANALOG);
		check_val("pd_out[1]", pd_out[1], ~8'h00);
		@(posedge clk);
		buttons_in <= 4'b0001;
		@(negedge clk);
		check_mask("paddle_but", paddle_but, 4'b0010);
		report_test("mouse claim", errs_before);
	endtask

	task automatic mask_limits_slots();
		int errs_before;
		errs_before = error_count;
		apply_reset(4'b0101);
		move_spinner(0, 8'hFF);
		expect_assign(4'b0001);
		// slot 1 is masked off so the next move goes to slot 2
		move_spinner(1, 8'h00);
		expect_assign(4'b0100);
		move_spinner(3, 8'hC4);
		expect_none(8);
		check_val("pd_out[1]", pd_out[1], '0);
		check_val("pd_out[3]", pd_out[3], '0);
		// with no slot enabled nothing is assigned
		apply_reset(4'b0000);
		move_spinner(2, 8'h3F);
		@(posedge clk);
		mouse.button <= 1'b1;
		expect_none(8);
		for (int i = 0; i < `PADDLE_PORTS; i++)
			check_val($sformatf("pd_out[%0d]", i), pd_out[i], '0);
		report_test("slot mask", errs_before);
	endtask

	initial begin
		void'($urandom(61));
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		tests_failed = 0;
		mouse_pos = 0;
		reset = 1'b1;
		mask = '0;
		mouse = '0;
		analog = '0;
		paddle = {`PADDLE_PORTS{8'h80}};
		buttons_in = '0;
		reset_clears_outputs();
		spinner_takes_slot();
		stick_takes_slot();
		mouse_takes_slot();
		mask_limits_slots();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== paddle_chooser.sv ====
// paddle chooser top level
// watches spinners, sticks and the mouse, binds the first to move
// to the next free paddle slot and presents the slot outputs

`timescale 1ns/1ps
`default_nettype none

`include "paddle_config.svh"

module paddle_chooser
	import paddle_pkg::*;
(
	input  wire logic                           clk,
	input  wire logic                           reset,
	input  port_mask_t                          mask,
	input  mouse_pkt_t                          mouse,
	input  stick_t       [`PADDLE_PORTS-1:0]    analog,
	input  paddle_val_t  [`PADDLE_PORTS-1:0]    paddle,
	input  port_mask_t                          buttons_in,
	output port_mask_t                          assigned,
	output paddle_val_t  [`PADDLE_PORTS-1:0]    pd_out,
	output source_kind_e [`PADDLE_PORTS-1:0]    paddle_type,
	output port_mask_t                          paddle_but
);

	paddle_val_t [`PADDLE_PORTS-1:0] xs_unsigned;
	paddle_val_t [`PADDLE_PORTS-1:0] ys_unsigned;
	port_mask_t  xs_select;
	port_mask_t  ys_select;
	port_mask_t  p_select;
	mouse_pos_t  mouse_x;
	logic        mouse_button;

	// assignment table between allocator and mux
	slot_if slots ();

	source_scanner source_scanner_i (
		.clk         (clk),
		.analog      (analog),
		.paddle      (paddle),
		.xs_unsigned (xs_unsigned),
		.ys_unsigned (ys_unsigned),
		.xs_select   (xs_select),
		.ys_select   (ys_select),
		.p_select    (p_select)
	);

	mouse_tracker mouse_tracker_i (
		.clk          (clk),
		.reset        (reset),
		.mouse        (mouse),
		.mouse_x      (mouse_x),
		.mouse_button (mouse_button)
	);

	paddle_allocator paddle_allocator_i (
		.clk          (clk),
		.reset        (reset),
		.mask         (mask),
		.xs_select    (xs_select),
		.ys_select    (ys_select),
		.p_select     (p_select),
		.mouse_button (mouse_button),
		.assigned     (assigned),
		.slots        (slots)
	);

	paddle_output_mux paddle_output_mux_i (
		.slots        (slots),
		.paddle       (paddle),
		.xs_unsigned  (xs_unsigned),
		.ys_unsigned  (ys_unsigned),
		.buttons_in   (buttons_in),
		.mouse_x      (mouse_x),
		.mouse_button (mouse_button),
		.pd_out       (pd_out),
		.paddle_type  (paddle_type),
		.paddle_but   (paddle_but)
	);

endmodule

`default_nettype wire

// ==== paddle_output_mux.sv ====
// paddle output mux
// presents each slot's inverted position and button from the
// source bound to it, unbound slots read as zero

`timescale 1ns/1ps
`default_nettype none

`include "paddle_config.svh"

module paddle_output_mux
	import paddle_pkg::*;
(
	slot_if.reader                              slots,
	input  paddle_val_t  [`PADDLE_PORTS-1:0]    paddle,
	input  paddle_val_t  [`PADDLE_PORTS-1:0]    xs_unsigned,
	input  paddle_val_t  [`PADDLE_PORTS-1:0]    ys_unsigned,
	input  port_mask_t                          buttons_in,
	input  mouse_pos_t                          mouse_x,
	input  wire logic                           mouse_button,
	output paddle_val_t  [`PADDLE_PORTS-1:0]    pd_out,
	output source_kind_e [`PADDLE_PORTS-1:0]    paddle_type,
	output port_mask_t                          paddle_but
);

	// low byte of the mouse position as offset binary
	paddle_val_t mouse_unsigned;

	assign mouse_unsigned = {~mouse_x[7], mouse_x[6:0]};

	always_comb begin
		for (int i = 0; i < `PADDLE_PORTS; i++) begin
			pd_out[i]     = '0;
			paddle_but[i] = 1'b0;
			if (slots.slot_valid[i]) begin
				case (slots.slot_kind[i])
					SPINNER: begin
						pd_out[i]     = ~paddle[slots.slot_index[i]];
						paddle_but[i] = buttons_in[slots.slot_index[i]];
					end
					ANALOG: begin
						pd_out[i] = slots.slot_x_axis[i] ?
							~xs_unsigned[slots.slot_index[i]] :
							~ys_unsigned[slots.slot_index[i]];
						paddle_but[i] = buttons_in[slots.slot_index[i]];
					end
					MOUSE: begin
						pd_out[i] = ~mouse_unsigned;
						// controller 0 fire doubles as mouse fire until stick 0 is taken
						paddle_but[i] = mouse_button | (slots.stick0_free & buttons_in[0]);
					end
					default: ;
				endcase
			end
		end
	end

	assign paddle_type = slots.slot_kind;

endmodule

`default_nettype wire

// ==== paddle_allocator.sv ====
// paddle slot allocator
// binds the winning moving source to the lowest free enabled slot,
// at most one per cycle, and holds the claims and the slot table

`timescale 1ns/1ps
`default_nettype none

`include "paddle_config.svh"

module paddle_allocator
	import paddle_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   reset,
	input  port_mask_t  mask,
	input  port_mask_t  xs_select,
	input  port_mask_t  ys_select,
	input  port_mask_t  p_select,
	input  wire logic   mouse_button,
	output port_mask_t  assigned,
	slot_if.owner       slots
);

	// claim flags where a whole stick is claimed at once
	port_mask_t   stick_claimed;
	port_mask_t   spinner_claimed;
	logic         mouse_claimed;

	port_mask_t   prev_ok;
	port_mask_t   eligible;
	logic         have_slot;
	port_idx_t    target_idx;

	port_mask_t   x_req;
	port_mask_t   y_req;
	port_mask_t   p_req;
	logic         mouse_req;
	logic         have_win;
	source_kind_e win_kind;
	port_idx_t    win_index;
	logic         win_x_axis;
	logic         grant;

	// slot below must be filled or masked off and slot 0 always qualifies
	assign prev_ok  = {slots.slot_valid[`PADDLE_PORTS-2:0] | ~mask[`PADDLE_PORTS-2:0], 1'b1};
	assign eligible = mask & ~slots.slot_valid & prev_ok;
	assign have_slot = |eligible;

	// lowest eligible slot only
	always_comb begin
		target_idx = '0;
		for (int i = `PADDLE_PORTS - 1; i >= 0; i--) begin
			if (eligible[i])
				target_idx = port_idx_t'(i);
		end
	end

	// unclaimed sources asking for a slot
	assign x_req     = xs_select & ~stick_claimed;
	assign y_req     = ys_select & ~stick_claimed;
	assign p_req     = p_select & ~spinner_claimed;
	assign mouse_req = mouse_button & ~mouse_claimed;

	// later assignments override earlier ones,
	// so the groups run from lowest to highest priority
	always_comb begin
		have_win   = 1'b0;
		win_kind   = SPINNER;
		win_index  = '0;
		win_x_axis = 1'b0;
		for (int i = 0; i < `PADDLE_PORTS; i++) begin
			if (x_req[i]) begin
				have_win   = 1'b1;
				win_kind   = ANALOG;
				win_index  = port_idx_t'(i);
				win_x_axis = 1'b1;
			end
		end
		for (int i = 0; i < `PADDLE_PORTS; i++) begin
			if (y_req[i]) begin
				have_win   = 1'b1;
				win_kind   = ANALOG;
				win_index  = port_idx_t'(i);
				win_x_axis = 1'b0;
			end
		end
		for (int i = 0; i < `PADDLE_PORTS; i++) begin
			if (p_req[i]) begin
				have_win   = 1'b1;
				win_kind   = SPINNER;
				win_index  = port_idx_t'(i);
				win_x_axis = 1'b0;
			end
		end
		// mouse beats everything
		if (mouse_req) begin
			have_win   = 1'b1;
			win_kind   = MOUSE;
			win_index  = '0;
			win_x_axis = 1'b0;
		end
	end

	assign grant = have_slot & have_win;

	// control state, table validity, kinds and claims
	always_ff @(posedge clk) begin
		if (reset) begin
			assigned         <= '0;
			slots.slot_valid <= '0;
			for (int i = 0; i < `PADDLE_PORTS; i++)
				slots.slot_kind[i] <= SPINNER;
			stick_claimed    <= '0;
			spinner_claimed  <= '0;
			mouse_claimed    <= 1'b0;
		end else begin
			// one cycle strobe
			assigned <= '0;
			if (grant) begin
				assigned[target_idx]         <= 1'b1;
				slots.slot_valid[target_idx] <= 1'b1;
				slots.slot_kind[target_idx]  <= win_kind;
				case (win_kind)
					SPINNER: spinner_claimed[win_index] <= 1'b1;
					ANALOG:  stick_claimed[win_index] <= 1'b1;
					MOUSE:   mouse_claimed <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// source selection for the granted slot
	always_ff @(posedge clk) begin
		if (grant) begin
			slots.slot_index[target_idx]  <= win_index;
			slots.slot_x_axis[target_idx] <= win_x_axis;
		end
	end

	assign slots.stick0_free = ~stick_claimed[0];

	a_assigned_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(assigned));

	// slots are never released short of reset
	a_valid_sticky: assert property (@(posedge clk) disable iff (reset)
		(slots.slot_valid & $past(slots.slot_valid)) == $past(slots.slot_valid));

	a_assign_free_slot: assert property (@(posedge clk) disable iff (reset)
		(assigned != '0) |-> ((assigned & $past(slots.slot_valid)) == '0));

endmodule

`default_nettype wire

// ==== mouse_tracker.sv ====
// mouse position tracker
// accumulates PS/2 x movement into a saturated signed position,
// one clamped step per strobe toggle

`timescale 1ns/1ps
`default_nettype none

`include "paddle_config.svh"

module mouse_tracker
	import paddle_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   reset,
	input  mouse_pkt_t  mouse,
	output mouse_pos_t  mouse_x,
	output logic        mouse_button
);

	localparam mouse_pos_t STEP_MAX = mouse_pos_t'(`MOUSE_STEP_LIMIT);
	localparam mouse_pos_t STEP_MIN = mouse_pos_t'(-`MOUSE_STEP_LIMIT);

	mouse_pkt_t        pkt_q;
	logic              strobe_prev;
	logic              strobe_toggle;
	mouse_pos_t        dx_raw;
	mouse_pos_t        dx_step;
	logic signed [9:0] pos_sum;

	// packet register, so a toggle shows one edge after the packet arrives
	always_ff @(posedge clk) begin
		pkt_q <= mouse;
		strobe_prev <= pkt_q.strobe;
	end

	assign strobe_toggle = pkt_q.strobe ^ strobe_prev;

	// 9-bit signed delta from sign and magnitude byte
	assign dx_raw = mouse_pos_t'({pkt_q.x_sign, pkt_q.x_delta});

	// overflow pins the step to the limit in the sign's direction
	always_comb begin
		if (pkt_q.x_ovf)
			dx_step = pkt_q.x_sign ? STEP_MIN : STEP_MAX;
		else if (dx_raw > STEP_MAX)
			dx_step = STEP_MAX;
		else if (dx_raw < STEP_MIN)
			dx_step = STEP_MIN;
		else
			dx_step = dx_raw;
	end

	// one extra bit so the sum cannot wrap before saturation
	assign pos_sum = $signed({mouse_x[8], mouse_x}) + $signed({dx_step[8], dx_step});

	always_ff @(posedge clk) begin
		if (reset) begin
			mouse_x <= '0;
		end else if (strobe_toggle) begin
			if (pos_sum < `MOUSE_POS_MIN)
				mouse_x <= mouse_pos_t'(`MOUSE_POS_MIN);
			else if (pos_sum > `MOUSE_POS_MAX)
				mouse_x <= mouse_pos_t'(`MOUSE_POS_MAX);
			else
				mouse_x <= mouse_pos_t'(pos_sum);
		end
	end

	// left button with the same one-register delay as the motion detectors
	assign mouse_button = pkt_q.button;

	a_pos_in_range: assert property (@(posedge clk) disable iff (reset)
		(mouse_x >= `MOUSE_POS_MIN) && (mouse_x <= `MOUSE_POS_MAX));

endmodule

`default_nettype wire

// ==== source_scanner.sv ====
// source scanner for sticks and spinners
// turns stick axes into offset binary and watches all twelve
// inputs for a jump to an extreme

`timescale 1ns/1ps
`default_nettype none

`include "paddle_config.svh"

module source_scanner
	import paddle_pkg::*;
(
	input  wire logic                           clk,
	input  stick_t      [`PADDLE_PORTS-1:0]     analog,
	input  paddle_val_t [`PADDLE_PORTS-1:0]     paddle,
	output paddle_val_t [`PADDLE_PORTS-1:0]     xs_unsigned,
	output paddle_val_t [`PADDLE_PORTS-1:0]     ys_unsigned,
	output port_mask_t                          xs_select,
	output port_mask_t                          ys_select,
	output port_mask_t                          p_select
);

	for (genvar i = 0; i < `PADDLE_PORTS; i++) begin : gen_stick
		// flipping the sign bit maps -128..127 onto 0..255
		assign xs_unsigned[i] = {~analog[i].x[`PADDLE_W-1], analog[i].x[`PADDLE_W-2:0]};
		assign ys_unsigned[i] = {~analog[i].y[`PADDLE_W-1], analog[i].y[`PADDLE_W-2:0]};

		motion_detect x_detect (
			.clk    (clk),
			.value  (xs_unsigned[i]),
			.select (xs_select[i])
		);

		motion_detect y_detect (
			.clk    (clk),
			.value  (ys_unsigned[i]),
			.select (ys_select[i])
		);
	end

	// spinners are already unsigned
	for (genvar i = 0; i < `PADDLE_PORTS; i++) begin : gen_spinner
		motion_detect p_detect (
			.clk    (clk),
			.value  (paddle[i]),
			.select (p_select[i])
		);
	end

endmodule

`default_nettype wire

// ==== motion_detect.sv ====
// motion detector for one position input
// flags a change that lands in either extreme quarter of the range,
// registered so select follows the sampling edge by one cycle

`timescale 1ns/1ps
`default_nettype none

`include "paddle_config.svh"

module motion_detect
	import paddle_pkg::*;
(
	input  wire logic        clk,
	input  paddle_val_t      value,
	output logic             select
);

	// sample from the previous edge
	paddle_val_t last_value;
	logic        in_band;
	logic        changed;

	// extreme band, top two bits both set or both clear
	assign in_band = (&value[`PADDLE_W-1:`PADDLE_W-2]) |
		~(|value[`PADDLE_W-1:`PADDLE_W-2]);

	assign changed = (value != last_value);

	always_ff @(posedge clk) begin
		last_value <= value;
		// one cycle pulse per qualifying change
		select <= changed & in_band;
	end

endmodule

`default_nettype wire

// ==== slot_if.sv ====
// paddle slot assignment table
// level-held state from the allocator, read by the output mux

`timescale 1ns/1ps
`default_nettype none

`include "paddle_config.svh"

interface slot_if
	import paddle_pkg::*;
();
	// slot has a source bound to it
	port_mask_t slot_valid;
	// what kind of source each slot carries
	source_kind_e [`PADDLE_PORTS-1:0] slot_kind;
	// which spinner or stick feeds the slot
	port_idx_t [`PADDLE_PORTS-1:0] slot_index;
	// analog slots only, 1 picks the x axis
	logic [`PADDLE_PORTS-1:0] slot_x_axis;
	// neither axis of stick 0 claimed yet
	logic stick0_free;

	modport owner (
		output slot_valid, slot_kind, slot_index, slot_x_axis, stick0_free
	);

	modport reader (
		input slot_valid, slot_kind, slot_index, slot_x_axis, stick0_free
	);

endinterface

`default_nettype wire

// ==== paddle_pkg.sv ====
// paddle chooser shared types
// positions, masks, indices, stick and PS/2 packet layouts, source kinds

`default_nettype none

`include "paddle_config.svh"

package paddle_pkg;

	typedef logic [`PADDLE_W-1:0] paddle_val_t;
	typedef logic [`PADDLE_PORTS-1:0] port_mask_t;
	typedef logic [$clog2(`PADDLE_PORTS)-1:0] port_idx_t;

	// two's complement stick with x in the low byte
	typedef struct packed {
		logic signed [`PADDLE_W-1:0] y;
		logic signed [`PADDLE_W-1:0] x;
	} stick_t;

	// PS/2 mouse packet plus a strobe that toggles once per packet
	typedef struct packed {
		logic       strobe;
		logic [7:0] y_delta;
		logic [7:0] x_delta;
		logic       y_ovf;
		logic       x_ovf;
		logic       y_sign;
		logic       x_sign;
		logic       always_one;
		logic       middle;
		logic       right;
		logic       button;
	} mouse_pkt_t;

	typedef logic signed [8:0] mouse_pos_t;

	typedef enum logic [3:0] {
		SPINNER = 4'd0,
		ANALOG  = 4'd1,
		MOUSE   = 4'd2
	} source_kind_e;

endpackage

`default_nettype wire

// ==== paddle_config.svh ====
// paddle chooser build parameters
// port count, position width and mouse tracking limits

`ifndef PADDLE_CONFIG_SVH
`define PADDLE_CONFIG_SVH

// number of paddle slots, also the number of sticks and spinners
`define PADDLE_PORTS 4

// width of one paddle position value
`define PADDLE_W 8

// largest magnitude accepted from a single mouse packet
`define MOUSE_STEP_LIMIT 64

// mouse position range, signed
`define MOUSE_POS_MIN (-128)
`define MOUSE_POS_MAX 127

`endif
